//--- dbg_report_cfg.svh
// Debug serial reporter configuration
// Default UART timing and report line lengths
`ifndef DBG_REPORT_CFG_SVH
`define DBG_REPORT_CFG_SVH

// ======================================================================
// UART timing
// ======================================================================
`define DBG_CLK_FREQ 51000000   // Pixel clock, Hz
`define DBG_BAUD 115200         // Line rate

// Bit time in clocks
`define DBG_CLKS_PER_BIT (`DBG_CLK_FREQ / `DBG_BAUD)

// ======================================================================
// Report lines, CR LF included
// ======================================================================
`define DBG_FRAME_LEN 31        // F:hhhh PC:hhh I:hhhh V:dddd s
`define DBG_PIXEL_LEN 25        // P:ddddd X:ddd Y:ddd B:d

`endif

//--- dbg_report_pkg.sv
// Debug reporter shared types
// FSM encodings, character types and ASCII digit helpers
`default_nettype none

package dbg_report_pkg;

    typedef logic [7:0] char_t;      // One ASCII character
    typedef logic [4:0] char_idx_t;  // Position within a report line

    // Report currently on the wire
    typedef enum logic {
        SRC_FRAME = 1'b0,
        SRC_PIXEL = 1'b1
    } report_src_t;

    typedef enum logic [1:0] {
        UART_IDLE  = 2'd0,
        UART_START = 2'd1,
        UART_DATA  = 2'd2,
        UART_STOP  = 2'd3
    } uart_state_t;

    typedef enum logic [1:0] {
        SEQ_IDLE = 2'd0,
        SEQ_SEND = 2'd1,
        SEQ_WAIT = 2'd2
    } seq_state_t;

    // Nibble to '0'..'9', 'A'..'F'
    function automatic char_t hex_ascii(input logic [3:0] nib);
        return (nib < 4'd10) ? char_t'(8'd48 + nib) : char_t'(8'd55 + nib);
    endfunction

    // Decimal digit to '0'..'9'
    function automatic char_t dec_ascii(input logic [3:0] dig);
        return char_t'(8'd48 + dig);
    endfunction

endpackage

`default_nettype wire

//--- frame_report.sv
// Frame report builder
// Counts frames and pixel-valid cycles, serves the frame line by index
`timescale 1ns/10ps
`default_nettype none

module frame_report import dbg_report_pkg::*; (
    input  wire        i_clk,
    input  wire        i_rst_n,
    input  wire        i_enable,
    input  wire        i_frame_tick,
    input  wire        i_pixel_valid,
    input  wire [11:0] i_cpu_pc,
    input  wire [15:0] i_cpu_instr_count,
    input  wire        i_cpu_running,
    input  wire        i_grant,         // One-cycle pulse from sequencer
    input  char_idx_t  i_char_idx,
    output logic       o_req,
    output char_t      o_char
);

    logic        r_tick_d;
    logic [15:0] r_frame_cnt;   // Frame ticks seen
    logic [15:0] r_frame_lat;   // Frame number of last completed frame
    logic [13:0] r_pv_cnt;      // Pixel-valid cycles, wraps at 10000
    logic [13:0] r_pv_lat;

    // Send snapshot
    logic [15:0] s_frame;
    logic [11:0] s_pc;
    logic [15:0] s_instr;
    logic [13:0] s_pv;
    logic        s_run;

    wire tick_rise = i_frame_tick & ~r_tick_d;

    // ======================================================================
    // Counters and request
    // ======================================================================
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            r_tick_d    <= 1'b0;
            r_frame_cnt <= 16'd0;
            r_frame_lat <= 16'd0;
            r_pv_cnt    <= 14'd0;
            r_pv_lat    <= 14'd0;
            o_req       <= 1'b0;
        end else begin
            r_tick_d <= i_frame_tick;
            if (tick_rise) begin
                r_frame_cnt <= r_frame_cnt + 16'd1;
                r_frame_lat <= r_frame_cnt;     // Number before increment
                r_pv_lat    <= r_pv_cnt;
                r_pv_cnt    <= i_pixel_valid ? 14'd1 : 14'd0;  // New frame
            end else if (i_pixel_valid) begin
                r_pv_cnt <= (r_pv_cnt == 14'd9999) ? 14'd0 : r_pv_cnt + 14'd1;
            end
            if (!i_enable)
                o_req <= 1'b0;
            else if (tick_rise)
                o_req <= 1'b1;    // New tick wins over a grant
            else if (i_grant)
                o_req <= 1'b0;
        end
    end

    // Snapshot on grant, CPU fields live
    always_ff @(posedge i_clk) begin
        if (i_grant) begin
            s_frame <= r_frame_lat;
            s_pv    <= r_pv_lat;
            s_pc    <= i_cpu_pc;
            s_instr <= i_cpu_instr_count;
            s_run   <= i_cpu_running;
        end
    end

    // ======================================================================
    // Line lookup
    // ======================================================================
    logic [3:0] v_d3, v_d2, v_d1, v_d0;   // V field digits
    assign v_d3 = 4'(s_pv / 14'd1000);
    assign v_d2 = 4'((s_pv / 14'd100) % 14'd10);
    assign v_d1 = 4'((s_pv / 14'd10) % 14'd10);
    assign v_d0 = 4'(s_pv % 14'd10);

    always_comb begin
        case (i_char_idx)
            5'd0:  o_char = "F";
            5'd1:  o_char = ":";
            5'd2:  o_char = hex_ascii(s_frame[15:12]);
            5'd3:  o_char = hex_ascii(s_frame[11:8]);
            5'd4:  o_char = hex_ascii(s_frame[7:4]);
            5'd5:  o_char = hex_ascii(s_frame[3:0]);
            5'd7:  o_char = "P";
            5'd8:  o_char = "C";
            5'd9:  o_char = ":";
            5'd10: o_char = hex_ascii(s_pc[11:8]);
            5'd11: o_char = hex_ascii(s_pc[7:4]);
            5'd12: o_char = hex_ascii(s_pc[3:0]);
            5'd14: o_char = "I";
            5'd15: o_char = ":";
            5'd16: o_char = hex_ascii(s_instr[15:12]);
            5'd17: o_char = hex_ascii(s_instr[11:8]);
            5'd18: o_char = hex_ascii(s_instr[7:4]);
            5'd19: o_char = hex_ascii(s_instr[3:0]);
            5'd21: o_char = "V";
            5'd22: o_char = ":";
            5'd23: o_char = dec_ascii(v_d3);
            5'd24: o_char = dec_ascii(v_d2);
            5'd25: o_char = dec_ascii(v_d1);
            5'd26: o_char = dec_ascii(v_d0);
            5'd28: o_char = s_run ? "R" : ".";   // Running flag
            5'd29: o_char = 8'h0D;               // CR
            5'd30: o_char = 8'h0A;               // LF
            default: o_char = " ";               // Field separators
        endcase
    end

endmodule

`default_nettype wire

//--- pixel_report.sv
// Pixel report builder
// Latches pixel fields on strobe edge, serves the pixel line by index
`timescale 1ns/10ps
`default_nettype none

module pixel_report import dbg_report_pkg::*; (
    input  wire        i_clk,
    input  wire        i_rst_n,
    input  wire        i_enable,
    input  wire        i_pixel_strobe,
    input  wire [31:0] i_pixel_count,
    input  wire [9:0]  i_pixel_x,
    input  wire [9:0]  i_pixel_y,
    input  wire [2:0]  i_pixel_brightness,
    input  wire        i_grant,
    input  char_idx_t  i_char_idx,
    output logic       o_req,
    output char_t      o_char
);

    logic        r_strobe_d;
    logic [31:0] r_cnt;         // Fields from last strobe edge
    logic [9:0]  r_x, r_y;
    logic [2:0]  r_bri;
    logic [16:0] s_cnt;         // Snapshot, count already mod 100000
    logic [9:0]  s_x, s_y;
    logic [2:0]  s_bri;

    wire strobe_rise = i_pixel_strobe & ~r_strobe_d;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            r_strobe_d <= 1'b0;
            o_req      <= 1'b0;
        end else begin
            r_strobe_d <= i_pixel_strobe;
            if (!i_enable)
                o_req <= 1'b0;
            else if (strobe_rise)
                o_req <= 1'b1;
            else if (i_grant)
                o_req <= 1'b0;
        end
    end

    // Capture on edge, move to snapshot on grant
    always_ff @(posedge i_clk) begin
        if (strobe_rise) begin
            r_cnt <= i_pixel_count;
            r_x   <= i_pixel_x;
            r_y   <= i_pixel_y;
            r_bri <= i_pixel_brightness;
        end
        if (i_grant) begin
            s_cnt <= 17'(r_cnt % 32'd100000);
            s_x   <= r_x;
            s_y   <= r_y;
            s_bri <= r_bri;
        end
    end

    // ======================================================================
    // Line lookup, all fields decimal
    // ======================================================================
    always_comb begin
        case (i_char_idx)
            5'd0:  o_char = "P";
            5'd1:  o_char = ":";
            5'd2:  o_char = dec_ascii(4'(s_cnt / 17'd10000));
            5'd3:  o_char = dec_ascii(4'((s_cnt / 17'd1000) % 17'd10));
            5'd4:  o_char = dec_ascii(4'((s_cnt / 17'd100) % 17'd10));
            5'd5:  o_char = dec_ascii(4'((s_cnt / 17'd10) % 17'd10));
            5'd6:  o_char = dec_ascii(4'(s_cnt % 17'd10));
            5'd8:  o_char = "X";
            5'd9:  o_char = ":";
            5'd10: o_char = dec_ascii(4'((s_x / 10'd100) % 10'd10));
            5'd11: o_char = dec_ascii(4'((s_x / 10'd10) % 10'd10));
            5'd12: o_char = dec_ascii(4'(s_x % 10'd10));
            5'd14: o_char = "Y";
            5'd15: o_char = ":";
            5'd16: o_char = dec_ascii(4'((s_y / 10'd100) % 10'd10));
            5'd17: o_char = dec_ascii(4'((s_y / 10'd10) % 10'd10));
            5'd18: o_char = dec_ascii(4'(s_y % 10'd10));
            5'd20: o_char = "B";
            5'd21: o_char = ":";
            5'd22: o_char = dec_ascii({1'b0, s_bri});  // 0..7
            5'd23: o_char = 8'h0D;
            5'd24: o_char = 8'h0A;
            default: o_char = " ";
        endcase
    end

endmodule

`default_nettype wire

//--- report_sequencer.sv
// Report sequencer
// Grants one builder at a time and feeds its line to the UART per character
`timescale 1ns/10ps
`default_nettype none
`include "dbg_report_cfg.svh"

module report_sequencer import dbg_report_pkg::*; (
    input  wire       i_clk,
    input  wire       i_rst_n,
    input  wire       i_frame_req,
    input  wire       i_pixel_req,
    input  char_t     i_frame_char,
    input  char_t     i_pixel_char,
    input  wire       i_tx_busy,
    output logic      o_frame_grant,
    output logic      o_pixel_grant,
    output char_idx_t o_char_idx,
    output logic      o_send,      // One-cycle strobe to UART
    output char_t     o_data
);

    localparam char_idx_t FRAME_LAST = char_idx_t'(`DBG_FRAME_LEN - 1);
    localparam char_idx_t PIXEL_LAST = char_idx_t'(`DBG_PIXEL_LEN - 1);

    seq_state_t  r_state;
    report_src_t r_src;     // Builder being sent
    char_idx_t   r_idx;

    // Grants only from idle, pixel first
    assign o_pixel_grant = (r_state == SEQ_IDLE) & i_pixel_req;
    assign o_frame_grant = (r_state == SEQ_IDLE) & i_frame_req & ~i_pixel_req;
    assign o_char_idx    = r_idx;

    wire char_t     cur_char = (r_src == SRC_PIXEL) ? i_pixel_char : i_frame_char;
    wire char_idx_t last_idx = (r_src == SRC_PIXEL) ? PIXEL_LAST : FRAME_LAST;

    // ======================================================================
    // Line FSM
    // ======================================================================
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            r_state <= SEQ_IDLE;
            r_src   <= SRC_FRAME;
            r_idx   <= '0;
            o_send  <= 1'b0;
        end else begin
            o_send <= 1'b0;
            case (r_state)
                SEQ_IDLE: begin
                    r_idx <= '0;
                    if (o_pixel_grant) begin
                        r_src   <= SRC_PIXEL;
                        r_state <= SEQ_SEND;
                    end else if (o_frame_grant) begin
                        r_src   <= SRC_FRAME;
                        r_state <= SEQ_SEND;
                    end
                end
                SEQ_SEND: if (!i_tx_busy) begin   // Snapshot valid from here
                    o_send  <= 1'b1;
                    r_state <= SEQ_WAIT;
                end
                SEQ_WAIT: if (i_tx_busy) begin    // Character taken
                    if (r_idx == last_idx) begin
                        r_state <= SEQ_IDLE;
                    end else begin
                        r_idx   <= r_idx + 1'b1;
                        r_state <= SEQ_SEND;
                    end
                end
                default: r_state <= SEQ_IDLE;
            endcase
        end
    end

    // Byte for the transmitter
    always_ff @(posedge i_clk) begin
        if (r_state == SEQ_SEND && !i_tx_busy)
            o_data <= cur_char;
    end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# Build the serial debug testbench with Verilator, run it, check the log
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f sim.f \
    --top-module serial_debug_tb -o serial_debug_sim
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/serial_debug_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q '\*\*\* FAILED \*\*\*' "$LOG"; then
    exit 1
fi
exit 0

//--- serial_debug.sv
// Debug serial reporter top level
// Frame and pixel builders share one UART through the sequencer
`timescale 1ns/10ps
`default_nettype none
`include "dbg_report_cfg.svh"

module serial_debug import dbg_report_pkg::*; #(
    parameter int CLKS_PER_BIT = `DBG_CLKS_PER_BIT
) (
    input  wire        i_clk,
    input  wire        i_rst_n,
    input  wire        i_enable,           // Low stops new reports
    input  wire        i_frame_tick,
    input  wire        i_pixel_valid,
    input  wire [11:0] i_cpu_pc,
    input  wire [15:0] i_cpu_instr_count,
    input  wire        i_cpu_running,
    input  wire        i_pixel_strobe,
    input  wire [31:0] i_pixel_count,
    input  wire [9:0]  i_pixel_x,
    input  wire [9:0]  i_pixel_y,
    input  wire [2:0]  i_pixel_brightness,
    output logic       o_uart_tx
);

    logic      w_frame_req, w_pixel_req;
    logic      w_frame_grant, w_pixel_grant;
    char_idx_t w_char_idx;
    char_t     w_frame_char, w_pixel_char;
    logic      w_send, w_busy;
    char_t     w_data;

    frame_report frame_report_i (
        .i_clk             (i_clk),
        .i_rst_n           (i_rst_n),
        .i_enable          (i_enable),
        .i_frame_tick      (i_frame_tick),
        .i_pixel_valid     (i_pixel_valid),
        .i_cpu_pc          (i_cpu_pc),
        .i_cpu_instr_count (i_cpu_instr_count),
        .i_cpu_running     (i_cpu_running),
        .i_grant           (w_frame_grant),
        .i_char_idx        (w_char_idx),
        .o_req             (w_frame_req),
        .o_char            (w_frame_char)
    );

    pixel_report pixel_report_i (
        .i_clk              (i_clk),
        .i_rst_n            (i_rst_n),
        .i_enable           (i_enable),
        .i_pixel_strobe     (i_pixel_strobe),
        .i_pixel_count      (i_pixel_count),
        .i_pixel_x          (i_pixel_x),
        .i_pixel_y          (i_pixel_y),
        .i_pixel_brightness (i_pixel_brightness),
        .i_grant            (w_pixel_grant),
        .i_char_idx         (w_char_idx),
        .o_req              (w_pixel_req),
        .o_char             (w_pixel_char)
    );

    report_sequencer report_sequencer_i (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_frame_req   (w_frame_req),
        .i_pixel_req   (w_pixel_req),
        .i_frame_char  (w_frame_char),
        .i_pixel_char  (w_pixel_char),
        .i_tx_busy     (w_busy),
        .o_frame_grant (w_frame_grant),
        .o_pixel_grant (w_pixel_grant),
        .o_char_idx    (w_char_idx),
        .o_send        (w_send),
        .o_data        (w_data)
    );

    uart_tx #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) uart_tx_i (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_send  (w_send),
        .i_data  (w_data),
        .o_tx    (o_uart_tx),
        .o_busy  (w_busy)
    );

endmodule

`default_nettype wire

//--- serial_debug_props.sv
// UART transmitter checks, bound into every uart_tx
// Idle line level and the response to an accepted send
`timescale 1ns/10ps
`default_nettype none

module uart_tx_props (
    input wire i_clk,
    input wire i_rst_n,
    input wire i_send,
    input wire i_tx,
    input wire i_busy
);

    // Line high whenever not busy
    idle_high: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !i_busy |-> i_tx)
        else $error("o_tx low while o_busy is low");

    send_busy: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_send && !i_busy) |=> i_busy)   // Accepted send
        else $error("accepted send not followed by o_busy");

    // Start bit right after the send
    send_start: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_send && !i_busy) |=> !i_tx)
        else $error("accepted send not followed by a start bit");

endmodule

bind uart_tx uart_tx_props uart_tx_props_i (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_send  (i_send),
    .i_tx    (o_tx),
    .i_busy  (o_busy)
);

`default_nettype wire

//--- serial_debug_tb.sv
// Serial debug reporter testbench
// Table-driven events, UART line decoder and a model of the report lines
`timescale 1ns/10ps
`default_nettype none
`include "dbg_report_cfg.svh"

module serial_debug_tb;

    localparam int CPB        = 8;          // Short bit time for simulation
    localparam int CLK_HALF   = 20;         // 40 ns period
    localparam int N_STEPS    = 12;
    localparam int QUIET      = 20 * CPB;   // Two character times
    localparam int MAX_CYCLES = N_STEPS * 2 * `DBG_FRAME_LEN * 10 * CPB + 10000;

    // Event kinds
    localparam int EV_IDLE  = 0;
    localparam int EV_FRAME = 1;
    localparam int EV_PIXEL = 2;
    localparam int EV_BOTH  = 3;

    typedef struct packed {
        logic [1:0]  kind;
        logic        en;
        logic [7:0]  pv;      // Pixel-valid cycles before the event
        logic [11:0] pc;
        logic [15:0] instr;
        logic        run;
        logic [31:0] cnt;
        logic [9:0]  x;
        logic [9:0]  y;
        logic [2:0]  bri;
    } step_t;

    logic        i_clk;
    logic        i_rst_n;
    logic        i_enable;
    logic        i_frame_tick;
    logic        i_pixel_valid;
    logic [11:0] i_cpu_pc;
    logic [15:0] i_cpu_instr_count;
    logic        i_cpu_running;
    logic        i_pixel_strobe;
    logic [31:0] i_pixel_count;
    logic [9:0]  i_pixel_x;
    logic [9:0]  i_pixel_y;
    logic [2:0]  i_pixel_brightness;
    wire         o_uart_tx;

    step_t steps [N_STEPS];
    int    n_steps   = 0;
    string exp_q [$];        // Model lines, oldest first
    string rx_q [$];         // Decoded lines
    string rx_cur    = "";
    string crlf;
    int    n_starts  = 0;    // Start bits seen
    int    errors    = 0;
    int    n_lines   = 0;
    int    cycles    = 0;
    int    frame_num = 0;    // Model frame counter
    int    pv_acc    = 0;    // Model pixel-valid count, current frame

    serial_debug #(
        .CLKS_PER_BIT (CPB)
    ) serial_debug_i (
        .i_clk              (i_clk),
        .i_rst_n            (i_rst_n),
        .i_enable           (i_enable),
        .i_frame_tick       (i_frame_tick),
        .i_pixel_valid      (i_pixel_valid),
        .i_cpu_pc           (i_cpu_pc),
        .i_cpu_instr_count  (i_cpu_instr_count),
        .i_cpu_running      (i_cpu_running),
        .i_pixel_strobe     (i_pixel_strobe),
        .i_pixel_count      (i_pixel_count),
        .i_pixel_x          (i_pixel_x),
        .i_pixel_y          (i_pixel_y),
        .i_pixel_brightness (i_pixel_brightness),
        .o_uart_tx          (o_uart_tx)
    );

    initial begin
        i_clk = 1'b0;
        forever #(CLK_HALF) i_clk = ~i_clk;
    end

    // Watchdog
    always @(posedge i_clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, expected report lines never arrived", cycles);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // ======================================================================
    // Line model
    // ======================================================================
    function automatic string hex_field(input longint val, input int digits);
        string s;
        s = "";
        for (int i = 0; i < digits; i++)
            s = {$sformatf("%0h", (val >> (4 * i)) & 15), s};
        return s.toupper();
    endfunction

    // Low digits only, so the value wraps at 10**digits
    function automatic string dec_field(input longint val, input int digits);
        string  s;
        longint v;
        s = "";
        v = val;
        for (int i = 0; i < digits; i++) begin
            s = {$sformatf("%0d", v % 10), s};
            v = v / 10;
        end
        return s;
    endfunction

    function automatic string frame_line(input step_t st, input int fnum, input int pv);
        string flag;
        if (st.run)
            flag = "R";
        else
            flag = ".";   // CPU halted
        return {"F:", hex_field(fnum, 4), " PC:", hex_field(st.pc, 3), " I:",
                hex_field(st.instr, 4), " V:", dec_field(pv, 4), " ", flag, crlf};
    endfunction

    function automatic string pixel_line(input step_t st);
        return {"P:", dec_field(st.cnt, 5), " X:", dec_field(st.x, 3), " Y:",
                dec_field(st.y, 3), " B:", dec_field(st.bri, 1), crlf};
    endfunction

    function automatic string kind_name(input logic [1:0] k);
        case (k)
            2'd1:    return "frame";
            2'd2:    return "pixel";
            2'd3:    return "both";
            default: return "idle";
        endcase
    endfunction

    // Table row with random field values
    task automatic add_step(input int kind, input bit en, input int pv);
        step_t st;
        st.kind  = 2'(kind);
        st.en    = en;
        st.pv    = 8'(pv);
        st.pc    = 12'($urandom);
        st.instr = 16'($urandom);
        st.run   = 1'($urandom);
        if (n_steps % 2 == 0)
            st.cnt = $urandom | 32'h0010_0000;   // Above 100000, wraps
        else
            st.cnt = $urandom % 100000;
        st.x     = 10'($urandom % 1000);
        st.y     = 10'($urandom % 1000);
        st.bri   = 3'($urandom);
        steps[n_steps] = st;
        n_steps++;
    endtask

    // Fields, then pixel-valid burst, then a one-cycle event
    task automatic drive_step(input step_t st);
        @(posedge i_clk);
        i_enable           <= st.en;
        i_cpu_pc           <= st.pc;
        i_cpu_instr_count  <= st.instr;
        i_cpu_running      <= st.run;
        i_pixel_count      <= st.cnt;
        i_pixel_x          <= st.x;
        i_pixel_y          <= st.y;
        i_pixel_brightness <= st.bri;
        @(posedge i_clk);
        if (st.pv != 0) begin
            i_pixel_valid <= 1'b1;
            repeat (st.pv) @(posedge i_clk);
            i_pixel_valid <= 1'b0;
        end
        @(posedge i_clk);
        i_frame_tick   <= (st.kind == EV_FRAME) || (st.kind == EV_BOTH);
        i_pixel_strobe <= (st.kind == EV_PIXEL) || (st.kind == EV_BOTH);
        @(posedge i_clk);
        i_frame_tick   <= 1'b0;
        i_pixel_strobe <= 1'b0;
        @(posedge i_clk);
    endtask

    task automatic compare_line(input string got, input string exp);
        n_lines++;
        assert (got.len() == exp.len()) else begin
            $display("Line length wrong: got %0d characters, expected %0d",
                     got.len(), exp.len());
            errors++;
        end
        for (int i = 0; i < exp.len() && i < got.len(); i++) begin
            assert (got[i] == exp[i]) else begin
                $display("Mismatch o_uart_tx char %0d: got %02h expected %02h",
                         i, got[i], exp[i]);
                errors++;
            end
        end
    endtask

    // ======================================================================
    // UART decoder, samples near mid-bit on falling clock edges
    // ======================================================================
    initial begin : uart_decoder
        logic [7:0] b;
        wait (i_rst_n === 1'b1);
        forever begin
            @(negedge o_uart_tx);
            n_starts++;
            repeat (CPB / 2) @(negedge i_clk);
            assert (o_uart_tx == 1'b0) else begin
                $display("Framing error: start bit not low at mid-bit");
                errors++;
            end
            for (int i = 0; i < 8; i++) begin
                repeat (CPB) @(negedge i_clk);
                b[i] = o_uart_tx;   // LSB first
            end
            repeat (CPB) @(negedge i_clk);
            assert (o_uart_tx == 1'b1) else begin
                $display("Framing error: stop bit not high at mid-bit");
                errors++;
            end
            rx_cur = {rx_cur, $sformatf("%c", b)};
            if (b == 8'h0a) begin
                rx_q.push_back(rx_cur);
                rx_cur = "";
            end
        end
    end

    // ======================================================================
    // Main sequence
    // ======================================================================
    initial begin : main_seq
        step_t st;
        int    err0;
        int    n_exp;
        int    base_starts;
        i_rst_n            = 1'b0;
        i_enable           = 1'b0;
        i_frame_tick       = 1'b0;
        i_pixel_valid      = 1'b0;
        i_cpu_pc           = '0;
        i_cpu_instr_count  = '0;
        i_cpu_running      = 1'b0;
        i_pixel_strobe     = 1'b0;
        i_pixel_count      = '0;
        i_pixel_x          = '0;
        i_pixel_y          = '0;
        i_pixel_brightness = '0;
        crlf = $sformatf("%c%c", 8'h0d, 8'h0a);
        void'($urandom(32'h7beffbab));

        //       kind      en    pv
        add_step(EV_FRAME, 1'b1,  5);
        add_step(EV_PIXEL, 1'b1,  0);
        add_step(EV_BOTH,  1'b1, 17);   // Pixel line goes first
        add_step(EV_FRAME, 1'b0,  9);   // Silent, frame still counts
        add_step(EV_PIXEL, 1'b0,  0);
        add_step(EV_FRAME, 1'b1,  3);
        add_step(EV_IDLE,  1'b1,  4);   // Valid cycles carry over
        add_step(EV_FRAME, 1'b1,  0);
        add_step(EV_PIXEL, 1'b1,  2);
        add_step(EV_BOTH,  1'b1, 30);
        add_step(EV_FRAME, 1'b1, 11);
        add_step(EV_PIXEL, 1'b1,  0);

        repeat (10) @(posedge i_clk);
        i_rst_n <= 1'b1;
        @(posedge i_clk);
        @(negedge i_clk);
        assert (o_uart_tx === 1'b1) else begin
            $display("Framing error: serial line not idle high after reset");
            errors++;
        end

        for (int s = 0; s < n_steps; s++) begin
            st   = steps[s];
            err0 = errors;
            drive_step(st);
            pv_acc += st.pv;
            if ((st.kind == EV_PIXEL || st.kind == EV_BOTH) && st.en)
                exp_q.push_back(pixel_line(st));
            if (st.kind == EV_FRAME || st.kind == EV_BOTH) begin
                if (st.en)
                    exp_q.push_back(frame_line(st, frame_num, pv_acc));
                frame_num++;
                pv_acc = 0;             // New frame
            end
            n_exp = exp_q.size();
            while (rx_q.size() < n_exp) @(posedge i_clk);
            base_starts = n_starts;
            repeat (QUIET) @(posedge i_clk);
            assert (n_starts == base_starts) else begin
                $display("Unexpected start bit after the reports of step %0d", s);
                errors++;
            end
            while (exp_q.size() > 0)
                compare_line(rx_q.pop_front(), exp_q.pop_front());
            $display("Step %0d %s en=%0d: %0d line(s) %s", s, kind_name(st.kind),
                     st.en, n_exp, (errors == err0) ? "ok" : "with errors");
        end

        $display("Summary: %0d steps, %0d lines checked, %0d errors",
                 n_steps, n_lines, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
+incdir+.
dbg_report_pkg.sv
uart_tx.sv
frame_report.sv
pixel_report.sv
report_sequencer.sv
serial_debug.sv
serial_debug_props.sv
serial_debug_tb.sv

//--- uart_tx.sv
// UART transmitter, 8N1
// Start bit, 8 data bits LSB first, one stop bit; line idles high
`timescale 1ns/10ps
`default_nettype none
`include "dbg_report_cfg.svh"

module uart_tx import dbg_report_pkg::*; #(
    parameter int CLKS_PER_BIT = `DBG_CLKS_PER_BIT
) (
    input  wire   i_clk,
    input  wire   i_rst_n,
    input  wire   i_send,    // Strobe, taken only in idle
    input  char_t i_data,
    output logic  o_tx,      // Serial line
    output logic  o_busy
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
    localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(CLKS_PER_BIT - 1);

    uart_state_t      r_state;
    logic [CNT_W-1:0] r_clk_cnt;   // Clocks within current bit
    logic [2:0]       r_bit_idx;   // Data bit number
    logic [7:0]       r_shift;     // Byte, shifted right per bit

    wire bit_done = (r_clk_cnt == BIT_LAST);

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            r_state   <= UART_IDLE;
            r_clk_cnt <= '0;
            r_bit_idx <= 3'd0;
            o_tx      <= 1'b1;   // Idle high
            o_busy    <= 1'b0;
        end else begin
            r_clk_cnt <= bit_done ? '0 : r_clk_cnt + 1'b1;
            case (r_state)
                UART_IDLE: begin
                    r_clk_cnt <= '0;
                    if (i_send) begin
                        r_shift <= i_data;
                        o_tx    <= 1'b0;   // Start bit begins right away
                        o_busy  <= 1'b1;
                        r_state <= UART_START;
                    end
                end
                UART_START: if (bit_done) begin
                    o_tx      <= r_shift[0];
                    r_bit_idx <= 3'd0;
                    r_state   <= UART_DATA;
                end
                UART_DATA: if (bit_done) begin
                    r_shift   <= r_shift >> 1;
                    r_bit_idx <= r_bit_idx + 3'd1;
                    if (r_bit_idx == 3'd7) begin
                        o_tx    <= 1'b1;   // Stop bit
                        r_state <= UART_STOP;
                    end else begin
                        o_tx <= r_shift[1];
                    end
                end
                UART_STOP: if (bit_done) begin
                    o_busy  <= 1'b0;
                    r_state <= UART_IDLE;
                end
                default: r_state <= UART_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire
